// File: filelist.f
source/regfile_pkg.sv
source/array_port_latch.sv
source/toysram_subarray.sv
source/read_local_eval.sv
source/regfile_64x24_2r1w.sv
testbench/regfile_chk.sv
testbench/regfile_monitor.sv
testbench/regfile_tb.sv

// File: testbench/regfile_tb.sv
module regfile_tb;

   logic               clk;
   logic               arst_n;
   logic               rd0_en;
   regfile_pkg::addr_t rd0_addr;
   logic               rd1_en;
   regfile_pkg::addr_t rd1_addr;
   logic               wr_en;
   regfile_pkg::addr_t wr_addr;
   regfile_pkg::data_t wr_dat;
   regfile_pkg::data_t rd0_dat;
   regfile_pkg::data_t rd1_dat;
   logic               track;
   int                 pending;
   int                 mismatches;
   int                 checks;
   int                 timeouts;

   regfile_64x24_2r1w DUT (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd0_en   (rd0_en),
      .rd0_addr (rd0_addr),
      .rd0_dat  (rd0_dat),
      .rd1_en   (rd1_en),
      .rd1_addr (rd1_addr),
      .rd1_dat  (rd1_dat),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_dat   (wr_dat)
   );

   regfile_monitor u_mon (
      .clk        (clk),
      .arst_n     (arst_n),
      .track      (track),
      .rd0_en     (rd0_en),
      .rd0_addr   (rd0_addr),
      .rd1_en     (rd1_en),
      .rd1_addr   (rd1_addr),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_dat     (wr_dat),
      .rd0_dat    (rd0_dat),
      .rd1_dat    (rd1_dat),
      .pending    (pending),
      .mismatches (mismatches),
      .checks     (checks)
   );

   bind array_port_latch regfile_chk u_chk (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
   end

   // distinct per address, every bit toggles over the sweep
   function automatic regfile_pkg::data_t sweep_word(input regfile_pkg::addr_t a);
      return {a, ~a, a ^ 6'h2a, a + 6'd13};
   endfunction

   function automatic regfile_pkg::addr_t rand_addr();
      return regfile_pkg::addr_t'($urandom_range(regfile_pkg::NUM_WORDS - 1));
   endfunction

   function automatic regfile_pkg::data_t rand_data();
      return regfile_pkg::data_t'($urandom);
   endfunction

   task automatic drive(input logic r0e, input regfile_pkg::addr_t r0a,
                        input logic r1e, input regfile_pkg::addr_t r1a,
                        input logic we, input regfile_pkg::addr_t wa,
                        input regfile_pkg::data_t wd);
      @(posedge clk);
      #1;
      rd0_en = r0e;
      rd0_addr = r0a;
      rd1_en = r1e;
      rd1_addr = r1a;
      wr_en = we;
      wr_addr = wa;
      wr_dat = wd;
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (arst_n !== 1'b1 && n < 10) begin
         @(posedge clk);
         n++;
      end
      if (arst_n !== 1'b1) begin
         $display("reset still asserted after 10 cycles");
         timeouts++;
      end
   endtask

   task automatic drain_monitor();
      int n;
      n = 0;
      while (pending != 0 && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (pending != 0) begin
         $display("monitor still holds %0d expected reads after 10 cycles", pending);
         timeouts++;
      end
   endtask

   initial begin : stimulus
      regfile_pkg::addr_t a;
      regfile_pkg::data_t d;
      int                 assert_fails;
      rd0_en = 1'b0;
      rd0_addr = '0;
      rd1_en = 1'b0;
      rd1_addr = '0;
      wr_en = 1'b0;
      wr_addr = '0;
      wr_dat = '0;
      track = 1'b1;
      timeouts = 0;
      void'($urandom(32'h51b));
      wait_reset_release();

      // full sweep, then read back on both ports
      for (int i = 0; i < regfile_pkg::NUM_WORDS; i++) begin
         a = regfile_pkg::addr_t'(i);
         drive(1'b0, '0, 1'b0, '0, 1'b1, a, sweep_word(a));
      end
      for (int i = 0; i < regfile_pkg::NUM_WORDS; i++) begin
         a = regfile_pkg::addr_t'(i);
         drive(1'b1, a, 1'b1, ~a, 1'b0, '0, '0);
      end

      // simultaneous reads, some to one address
      for (int i = 0; i < 100; i++) begin
         a = rand_addr();
         if ($urandom_range(3) == 0) begin
            drive(1'b1, a, 1'b1, a, 1'b0, '0, '0);
         end else begin
            drive(1'b1, a, 1'b1, rand_addr(), 1'b0, '0, '0);
         end
      end

      // read beside a write to the same word
      for (int i = 0; i < 8; i++) begin
         a = rand_addr();
         d = rand_data();
         drive(1'b1, a, 1'b0, '0, 1'b1, a, d);
         drive(1'b1, a, 1'b1, a, 1'b0, '0, '0);
      end

      // disabled ports
      for (int i = 0; i < 16; i++) begin
         a = rand_addr();
         drive(1'b0, a, 1'b0, rand_addr(), 1'b0, a, rand_data());
         drive(1'b1, a, 1'b1, a, 1'b0, '0, '0);
      end

      for (int i = 0; i < 2000; i++) begin
         drive($urandom_range(3) != 0, rand_addr(), $urandom_range(3) != 0, rand_addr(),
               $urandom_range(1) == 1, rand_addr(), rand_data());
      end

      drive(1'b0, '0, 1'b0, '0, 1'b0, '0, '0);
      @(posedge clk);
      #1;
      track = 1'b0;
      drain_monitor();

      assert_fails = DUT.u_latch.u_chk.fails;
      $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts, %0d checks",
               mismatches, assert_fails, timeouts, checks);
      if (mismatches == 0 && assert_fails == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: testbench/regfile_monitor.sv
module regfile_monitor (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               track,
   input  logic               rd0_en,
   input  regfile_pkg::addr_t rd0_addr,
   input  logic               rd1_en,
   input  regfile_pkg::addr_t rd1_addr,
   input  logic               wr_en,
   input  regfile_pkg::addr_t wr_addr,
   input  regfile_pkg::data_t wr_dat,
   input  regfile_pkg::data_t rd0_dat,
   input  regfile_pkg::data_t rd1_dat,
   output int                 pending,
   output int                 mismatches,
   output int                 checks
);

   typedef struct packed {
      logic [31:0]        cycle;
      logic               port;
      regfile_pkg::addr_t addr;
      regfile_pkg::data_t value;
   } expect_t;

   regfile_pkg::data_t shadow [regfile_pkg::NUM_WORDS];
   bit                 known [regfile_pkg::NUM_WORDS];
   expect_t            exp_q [$];
   logic [31:0]        cycle;

   // contents before any write sampled at the same edge
   function automatic regfile_pkg::data_t expected_read(input logic en,
                                                        input regfile_pkg::addr_t addr);
      if (en) begin
         return shadow[addr];
      end
      return '0;
   endfunction

   task automatic note_read(input logic port, input logic en, input regfile_pkg::addr_t addr);
      expect_t e;
      // never-written words are skipped
      if (en && !known[addr]) begin
         return;
      end
      e.cycle = cycle;
      e.port  = port;
      e.addr  = addr;
      e.value = expected_read(en, addr);
      exp_q.push_back(e);
   endtask

   task automatic compare_due();
      expect_t            e;
      regfile_pkg::data_t got;
      while (exp_q.size() > 0 && exp_q[0].cycle + 1 == cycle) begin
         e = exp_q.pop_front();
         got = e.port ? rd1_dat : rd0_dat;
         checks++;
         if (got !== e.value) begin
            mismatches++;
            $display("FAILED %0t rd%0d addr %0d expected %h got %h",
                     $time, e.port, e.addr, e.value, got);
         end
      end
   endtask

   initial begin
      pending = 0;
      mismatches = 0;
      checks = 0;
      cycle = '0;
      forever begin
         @(posedge clk);
         cycle = cycle + 1;
         if (arst_n === 1'b1 && track) begin
            note_read(1'b0, rd0_en, rd0_addr);
            note_read(1'b1, rd1_en, rd1_addr);
         end
         if (arst_n === 1'b1 && wr_en) begin
            shadow[wr_addr] = wr_dat;
            known[wr_addr] = 1'b1;
         end
         // outputs settled half a cycle after the edge
         @(negedge clk);
         if (arst_n !== 1'b1) begin
            checks++;
            if (rd0_dat !== '0 || rd1_dat !== '0) begin
               mismatches++;
               $display("FAILED %0t read data %h %h not zero in reset",
                        $time, rd0_dat, rd1_dat);
            end
         end
         compare_due();
         pending = exp_q.size();
      end
   end

endmodule

// File: testbench/regfile_chk.sv
module regfile_chk (
   input logic              clk,
   input logic              arst_n,
   input logic              rd0_en,
   input logic              rd1_en,
   input logic              wr_en,
   input regfile_pkg::pd2_t rd0_bank,
   input regfile_pkg::pd4_t rd0_a12,
   input regfile_pkg::pd2_t rd0_a3,
   input regfile_pkg::pd4_t rd0_a45,
   input regfile_pkg::pd2_t rd1_bank,
   input regfile_pkg::pd4_t rd1_a12,
   input regfile_pkg::pd2_t rd1_a3,
   input regfile_pkg::pd4_t rd1_a45,
   input regfile_pkg::pd2_t wr_bank,
   input regfile_pkg::pd4_t wr_a12,
   input regfile_pkg::pd2_t wr_a3,
   input regfile_pkg::pd4_t wr_a45
);

   int fails = 0;

   // at most one line per predecode group
   rd0_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(rd0_bank) && $onehot0(rd0_a12) && $onehot0(rd0_a3) && $onehot0(rd0_a45))
      else begin
         $error("rd0 predecode group has several active lines");
         fails++;
      end

   rd1_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(rd1_bank) && $onehot0(rd1_a12) && $onehot0(rd1_a3) && $onehot0(rd1_a45))
      else begin
         $error("rd1 predecode group has several active lines");
         fails++;
      end

   wr_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(wr_bank) && $onehot0(wr_a12) && $onehot0(wr_a3) && $onehot0(wr_a45))
      else begin
         $error("write predecode group has several active lines");
         fails++;
      end

   // disabled port leaves all its lines low
   rd0_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !rd0_en |=> {rd0_bank, rd0_a12, rd0_a3, rd0_a45} == '0)
      else begin
         $error("rd0 lines active after a disabled cycle");
         fails++;
      end

   rd1_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !rd1_en |=> {rd1_bank, rd1_a12, rd1_a3, rd1_a45} == '0)
      else begin
         $error("rd1 lines active after a disabled cycle");
         fails++;
      end

   wr_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !wr_en |=> {wr_bank, wr_a12, wr_a3, wr_a45} == '0)
      else begin
         $error("write lines active after a disabled cycle");
         fails++;
      end

endmodule

// File: source/regfile_64x24_2r1w.sv
module regfile_64x24_2r1w (
   input  logic               clk,
   input  logic               arst_n,

   input  logic               rd0_en,
   input  regfile_pkg::addr_t rd0_addr,
   output regfile_pkg::data_t rd0_dat,

   input  logic               rd1_en,
   input  regfile_pkg::addr_t rd1_addr,
   output regfile_pkg::data_t rd1_dat,

   input  logic               wr_en,
   input  regfile_pkg::addr_t wr_addr,
   input  regfile_pkg::data_t wr_dat
);

   regfile_pkg::pd2_t  rd0_bank;
   regfile_pkg::pd4_t  rd0_a12;
   regfile_pkg::pd2_t  rd0_a3;
   regfile_pkg::pd4_t  rd0_a45;
   regfile_pkg::pd2_t  rd1_bank;
   regfile_pkg::pd4_t  rd1_a12;
   regfile_pkg::pd2_t  rd1_a3;
   regfile_pkg::pd4_t  rd1_a45;
   regfile_pkg::pd2_t  wr_bank;
   regfile_pkg::pd4_t  wr_a12;
   regfile_pkg::pd2_t  wr_a3;
   regfile_pkg::pd4_t  wr_a45;
   regfile_pkg::data_t wr_bits;

   regfile_pkg::half_t rbl0_n [regfile_pkg::NUM_SUBS];
   regfile_pkg::half_t rbl1_n [regfile_pkg::NUM_SUBS];

   array_port_latch u_latch (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd0_en   (rd0_en),
      .rd0_addr (rd0_addr),
      .rd1_en   (rd1_en),
      .rd1_addr (rd1_addr),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_dat   (wr_dat),
      .rd0_bank (rd0_bank),
      .rd0_a12  (rd0_a12),
      .rd0_a3   (rd0_a3),
      .rd0_a45  (rd0_a45),
      .rd1_bank (rd1_bank),
      .rd1_a12  (rd1_a12),
      .rd1_a3   (rd1_a3),
      .rd1_a45  (rd1_a45),
      .wr_bank  (wr_bank),
      .wr_a12   (wr_a12),
      .wr_a3    (wr_a3),
      .wr_a45   (wr_a45),
      .wr_bits  (wr_bits)
   );

   // 4 word groups x 2 bit halves
   for (genvar g = 0; g < regfile_pkg::NUM_GROUPS; g++) begin : g_grp
      for (genvar h = 0; h < regfile_pkg::NUM_HALVES; h++) begin : g_half
         toysram_subarray #(
            .GROUP (g),
            .HALF  (h)
         ) u_sub (
            .clk      (clk),
            .rd0_bank (rd0_bank),
            .rd0_a12  (rd0_a12),
            .rd0_a3   (rd0_a3),
            .rd0_a45  (rd0_a45),
            .rd1_bank (rd1_bank),
            .rd1_a12  (rd1_a12),
            .rd1_a3   (rd1_a3),
            .rd1_a45  (rd1_a45),
            .wr_bank  (wr_bank),
            .wr_a12   (wr_a12),
            .wr_a3    (wr_a3),
            .wr_a45   (wr_a45),
            .wr_bits  (wr_bits[h*regfile_pkg::SUB_BITS +: regfile_pkg::SUB_BITS]),
            .rbl0_n   (rbl0_n[g*regfile_pkg::NUM_HALVES + h]),
            .rbl1_n   (rbl1_n[g*regfile_pkg::NUM_HALVES + h])
         );
      end
   end

   read_local_eval u_eval (
      .clk     (clk),
      .arst_n  (arst_n),
      .rbl0_n  (rbl0_n),
      .rbl1_n  (rbl1_n),
      .rd0_dat (rd0_dat),
      .rd1_dat (rd1_dat)
   );

endmodule

// File: source/read_local_eval.sv
module read_local_eval (
   input  logic               clk,
   input  logic               arst_n,

   // subarray s is group s/2, half s%2
   input  regfile_pkg::half_t rbl0_n [regfile_pkg::NUM_SUBS],
   input  regfile_pkg::half_t rbl1_n [regfile_pkg::NUM_SUBS],

   output regfile_pkg::data_t rd0_dat,
   output regfile_pkg::data_t rd1_dat
);

   regfile_pkg::data_t merge0;
   regfile_pkg::data_t merge1;

   // four groups per half, idle groups contribute zero
   always_comb begin
      merge0 = '0;
      merge1 = '0;
      for (int h = 0; h < regfile_pkg::NUM_HALVES; h++) begin
         for (int g = 0; g < regfile_pkg::NUM_GROUPS; g++) begin
            merge0[h*regfile_pkg::SUB_BITS +: regfile_pkg::SUB_BITS] =
               merge0[h*regfile_pkg::SUB_BITS +: regfile_pkg::SUB_BITS] |
               ~rbl0_n[g*regfile_pkg::NUM_HALVES + h];
            merge1[h*regfile_pkg::SUB_BITS +: regfile_pkg::SUB_BITS] =
               merge1[h*regfile_pkg::SUB_BITS +: regfile_pkg::SUB_BITS] |
               ~rbl1_n[g*regfile_pkg::NUM_HALVES + h];
         end
      end
   end

   // capture one edge after the port latch
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd0_dat <= '0;
         rd1_dat <= '0;
      end else begin
         rd0_dat <= merge0;
         rd1_dat <= merge1;
      end
   end

endmodule

// File: source/toysram_subarray.sv
module toysram_subarray #(
   parameter int GROUP = 0,
   parameter int HALF  = 0
) (
   input  logic               clk,

   input  regfile_pkg::pd2_t  rd0_bank,
   input  regfile_pkg::pd4_t  rd0_a12,
   input  regfile_pkg::pd2_t  rd0_a3,
   input  regfile_pkg::pd4_t  rd0_a45,

   input  regfile_pkg::pd2_t  rd1_bank,
   input  regfile_pkg::pd4_t  rd1_a12,
   input  regfile_pkg::pd2_t  rd1_a3,
   input  regfile_pkg::pd4_t  rd1_a45,

   input  regfile_pkg::pd2_t  wr_bank,
   input  regfile_pkg::pd4_t  wr_a12,
   input  regfile_pkg::pd2_t  wr_a3,
   input  regfile_pkg::pd4_t  wr_a45,

   input  regfile_pkg::half_t wr_bits,

   output regfile_pkg::half_t rbl0_n,
   output regfile_pkg::half_t rbl1_n
);

   // group is a0 a1 with a0 picking the bank line
   localparam int BANK   = GROUP / 2;
   localparam int GRP_LO = GROUP % 2;

   regfile_pkg::wl_t   rwl0;
   regfile_pkg::wl_t   rwl1;
   regfile_pkg::wl_t   wwl;
   regfile_pkg::half_t mem [regfile_pkg::SUB_WORDS];
   regfile_pkg::half_t sel0;
   regfile_pkg::half_t sel1;

   // row is a2 a3 a4 a5
   for (genvar r = 0; r < regfile_pkg::SUB_WORDS; r++) begin : g_row
      localparam int A12 = GRP_LO * 2 + r / 8;
      localparam int A3  = (r / 4) % 2;
      localparam int A45 = r % 4;

      assign rwl0[r] = rd0_bank[BANK] & rd0_a12[A12] & rd0_a3[A3] & rd0_a45[A45];
      assign rwl1[r] = rd1_bank[BANK] & rd1_a12[A12] & rd1_a3[A3] & rd1_a45[A45];
      assign wwl[r]  = wr_bank[BANK] & wr_a12[A12] & wr_a3[A3] & wr_a45[A45];
   end

   // cell write
   always_ff @(posedge clk) begin
      for (int r = 0; r < regfile_pkg::SUB_WORDS; r++) begin
         if (wwl[r]) begin
            mem[r] <= wr_bits;
         end
      end
   end

   // dot-or of selected cells onto the precharged lines
   always_comb begin
      sel0 = '0;
      sel1 = '0;
      for (int r = 0; r < regfile_pkg::SUB_WORDS; r++) begin
         if (rwl0[r]) begin
            sel0 = sel0 | mem[r];
         end
         if (rwl1[r]) begin
            sel1 = sel1 | mem[r];
         end
      end
   end

   // pulled low where the cell holds 1
   assign rbl0_n = ~sel0;
   assign rbl1_n = ~sel1;

endmodule

// File: source/array_port_latch.sv
module array_port_latch (
   input  logic               clk,
   input  logic               arst_n,

   input  logic               rd0_en,
   input  regfile_pkg::addr_t rd0_addr,
   input  logic               rd1_en,
   input  regfile_pkg::addr_t rd1_addr,
   input  logic               wr_en,
   input  regfile_pkg::addr_t wr_addr,
   input  regfile_pkg::data_t wr_dat,

   output regfile_pkg::pd2_t  rd0_bank,
   output regfile_pkg::pd4_t  rd0_a12,
   output regfile_pkg::pd2_t  rd0_a3,
   output regfile_pkg::pd4_t  rd0_a45,

   output regfile_pkg::pd2_t  rd1_bank,
   output regfile_pkg::pd4_t  rd1_a12,
   output regfile_pkg::pd2_t  rd1_a3,
   output regfile_pkg::pd4_t  rd1_a45,

   output regfile_pkg::pd2_t  wr_bank,
   output regfile_pkg::pd4_t  wr_a12,
   output regfile_pkg::pd2_t  wr_a3,
   output regfile_pkg::pd4_t  wr_a45,

   output regfile_pkg::data_t wr_bits
);

   // 1 of 2 decode, [0] is the complement line
   function automatic regfile_pkg::pd2_t dec2(input logic en, input logic a);
      return {en & ~a, en & a};
   endfunction

   // 2 of 4 decode, a[0] is the more significant bit
   function automatic regfile_pkg::pd4_t dec4(input logic en, input logic [0:1] a);
      regfile_pkg::pd4_t lines;
      for (int i = 0; i < 4; i++) begin
         lines[i] = en && (a == 2'(i));
      end
      return lines;
   endfunction

   // decode ahead of the flops so the lines leave the latch registered
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd0_bank <= '0;
         rd0_a12  <= '0;
         rd0_a3   <= '0;
         rd0_a45  <= '0;
         rd1_bank <= '0;
         rd1_a12  <= '0;
         rd1_a3   <= '0;
         rd1_a45  <= '0;
         wr_bank  <= '0;
         wr_a12   <= '0;
         wr_a3    <= '0;
         wr_a45   <= '0;
         wr_bits  <= '0;
      end else begin
         // read port 0
         rd0_bank <= dec2(rd0_en, rd0_addr[0]);
         rd0_a12  <= dec4(rd0_en, rd0_addr[1:2]);
         rd0_a3   <= dec2(rd0_en, rd0_addr[3]);
         rd0_a45  <= dec4(rd0_en, rd0_addr[4:5]);

         // read port 1
         rd1_bank <= dec2(rd1_en, rd1_addr[0]);
         rd1_a12  <= dec4(rd1_en, rd1_addr[1:2]);
         rd1_a3   <= dec2(rd1_en, rd1_addr[3]);
         rd1_a45  <= dec4(rd1_en, rd1_addr[4:5]);

         // write port, data travels with its word lines
         wr_bank  <= dec2(wr_en, wr_addr[0]);
         wr_a12   <= dec4(wr_en, wr_addr[1:2]);
         wr_a3    <= dec2(wr_en, wr_addr[3]);
         wr_a45   <= dec4(wr_en, wr_addr[4:5]);
         wr_bits  <= wr_dat;
      end
   end

endmodule

// File: source/regfile_pkg.sv
package regfile_pkg;

   // array geometry
   localparam int NUM_WORDS  = 64;
   localparam int SUB_WORDS  = 16;
   localparam int SUB_BITS   = 12;
   localparam int NUM_GROUPS = NUM_WORDS / SUB_WORDS;
   localparam int NUM_HALVES = 2;
   localparam int NUM_SUBS   = NUM_GROUPS * NUM_HALVES;
   localparam int DATA_W     = SUB_BITS * NUM_HALVES;
   localparam int ADDR_W     = $clog2(NUM_WORDS);

   // bit 0 is a0, the most significant address bit
   typedef logic [0:ADDR_W-1] addr_t;

   // half h of a word is bits h*12 to h*12+11
   typedef logic [0:DATA_W-1] data_t;

   // half-word, also one bit-line bundle of a subarray
   typedef logic [0:SUB_BITS-1] half_t;

   // one line per subarray row
   typedef logic [0:SUB_WORDS-1] wl_t;

   // predecode groups, line i active when the decoded bits equal i
   typedef logic [0:1] pd2_t;
   typedef logic [0:3] pd4_t;

endpackage
